/* src/mbtrain_pkg.sv */
package mbtrain_pkg;

	// one enable and one ack per training substep
	localparam int NUM_STEPS   = 13;
	localparam int STEP_CODE_W = 4;
	localparam int MUX_SEL_W   = 3;
	localparam int ENTRY_W     = 2;

	// substep code, doubles as sideband substate and enable bit index
	typedef enum logic [STEP_CODE_W-1:0] {
		STEP_VALID_VREF         = 4'd0,
		STEP_DATA_VREF          = 4'd1,
		STEP_SPEED_IDLE         = 4'd2,
		STEP_TX_SELF_CAL        = 4'd3,
		STEP_RX_CLK_CAL         = 4'd4,
		STEP_VALID_TRAIN_CENTER = 4'd5,
		STEP_VALID_TRAIN_VREF   = 4'd6,
		STEP_DATA_TRAIN_CENTER1 = 4'd7,
		STEP_DATA_TRAIN_VREF    = 4'd8,
		STEP_RX_DESKEW          = 4'd9,
		STEP_DATA_TRAIN_CENTER2 = 4'd10,
		STEP_LINK_SPEED         = 4'd11,
		STEP_REPAIR             = 4'd12
	} step_code_t;

	// pattern generator / detector class
	typedef enum logic [MUX_SEL_W-1:0] {
		MUX_VREF_CAL     = 3'd0,
		MUX_SELF_CAL     = 3'd1,
		MUX_LINK_SPEED   = 3'd2,
		MUX_REPAIR       = 3'd3,
		MUX_TRAIN_CENTER = 3'd4,
		MUX_RX_CAL       = 3'd5
	} mux_sel_t;

	// resolved retrain state selects where training begins
	typedef enum logic [ENTRY_W-1:0] {
		ENTRY_FULL          = 2'b00,
		ENTRY_TX_SELF_CAL   = 2'b01,
		ENTRY_REPAIR        = 2'b10,
		ENTRY_SPEED_DEGRADE = 2'b11
	} entry_t;

	function automatic mux_sel_t step_mux_sel(input step_code_t code);
		mux_sel_t sel;
		case (code)
			STEP_VALID_VREF, STEP_DATA_VREF,
			STEP_VALID_TRAIN_VREF, STEP_DATA_TRAIN_VREF:    sel = MUX_VREF_CAL;
			STEP_SPEED_IDLE, STEP_TX_SELF_CAL:              sel = MUX_SELF_CAL;
			STEP_VALID_TRAIN_CENTER, STEP_DATA_TRAIN_CENTER1,
			STEP_DATA_TRAIN_CENTER2:                        sel = MUX_TRAIN_CENTER;
			STEP_RX_CLK_CAL, STEP_RX_DESKEW:                sel = MUX_RX_CAL;
			STEP_LINK_SPEED:                                sel = MUX_LINK_SPEED;
			STEP_REPAIR:                                    sel = MUX_REPAIR;
			default:                                        sel = MUX_VREF_CAL;
		endcase
		return sel;
	endfunction

endpackage

/* src/mbtrain_step_handshake.sv */
`timescale 1ns/1ps

module mbtrain_step_handshake (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_step_start,
	input  mbtrain_pkg::step_code_t          i_step_code,
	input  logic [mbtrain_pkg::NUM_STEPS-1:0] i_step_ack,
	output logic [mbtrain_pkg::NUM_STEPS-1:0] o_step_en,
	output mbtrain_pkg::step_code_t          o_sideband_substate,
	output mbtrain_pkg::mux_sel_t            o_mux_sel,
	output logic                             o_step_done
);

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_WAIT_HIGH,
		HS_WAIT_LOW
	} hs_state_t;

	hs_state_t                          hs_state;
	mbtrain_pkg::step_code_t            code_q;
	mbtrain_pkg::mux_sel_t              mux_q;
	logic [mbtrain_pkg::NUM_STEPS-1:0]  step_en_q;
	logic                               ack_cur;

	// ack of the substep currently in flight
	assign ack_cur = i_step_ack[code_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hs_state  <= HS_IDLE;
			code_q    <= mbtrain_pkg::STEP_VALID_VREF;
			mux_q     <= mbtrain_pkg::MUX_VREF_CAL;
			step_en_q <= '0;
		end else begin
			if (i_step_start) begin
				// new substep: one enable bit, code and pattern class together
				hs_state             <= HS_WAIT_HIGH;
				code_q               <= i_step_code;
				mux_q                <= mbtrain_pkg::step_mux_sel(i_step_code);
				step_en_q            <= '0;
				step_en_q[i_step_code] <= 1'b1;
			end else begin
				case (hs_state)
					HS_WAIT_HIGH: begin
						// remote side took the step, release the enable
						if (ack_cur) begin
							step_en_q <= '0;
							hs_state  <= HS_WAIT_LOW;
						end
					end
					HS_WAIT_LOW: begin
						if (!ack_cur) begin
							hs_state <= HS_IDLE;
						end
					end
					default: hs_state <= HS_IDLE;
				endcase
			end
		end
	end

	// done as soon as the ack is seen back low, so the next enable
	// can follow two cycles after that sample
	assign o_step_done = (hs_state == HS_WAIT_LOW) && !ack_cur;

	assign o_step_en           = step_en_q;
	assign o_sideband_substate = code_q;
	assign o_mux_sel           = mux_q;

endmodule

/* src/mbtrain_sequencer.sv */
`timescale 1ns/1ps

module mbtrain_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_en,
	input  mbtrain_pkg::entry_t     i_entry,
	input  logic                    i_step_done,
	input  logic                    i_phy_retrain_req,
	input  logic                    i_error_req,
	input  logic                    i_speed_degrade_req,
	output logic                    o_step_start,
	output mbtrain_pkg::step_code_t o_step_code,
	output logic                    o_phyretrain_en,
	output logic                    o_mbtrain_ack,
	output logic                    o_train_start,
	output logic                    o_speed_degrade,
	output logic                    o_repair_enter,
	output logic                    o_linkspeed_exit,
	output logic                    o_repair_exit,
	output logic                    o_finish
);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_RUNNING,
		PH_FINISHED
	} phase_t;

	phase_t                  phase_q;
	mbtrain_pkg::step_code_t code_q;

	// first substep for each resolved retrain state
	function automatic mbtrain_pkg::step_code_t entry_step(input mbtrain_pkg::entry_t entry);
		mbtrain_pkg::step_code_t code;
		case (entry)
			mbtrain_pkg::ENTRY_TX_SELF_CAL:   code = mbtrain_pkg::STEP_TX_SELF_CAL;
			mbtrain_pkg::ENTRY_REPAIR:        code = mbtrain_pkg::STEP_REPAIR;
			mbtrain_pkg::ENTRY_SPEED_DEGRADE: code = mbtrain_pkg::STEP_SPEED_IDLE;
			default:                          code = mbtrain_pkg::STEP_VALID_VREF;
		endcase
		return code;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q          <= PH_IDLE;
			code_q           <= mbtrain_pkg::STEP_VALID_VREF;
			o_step_start     <= 1'b0;
			o_phyretrain_en  <= 1'b0;
			o_mbtrain_ack    <= 1'b0;
			o_train_start    <= 1'b0;
			o_speed_degrade  <= 1'b0;
			o_repair_enter   <= 1'b0;
			o_linkspeed_exit <= 1'b0;
			o_repair_exit    <= 1'b0;
			o_finish         <= 1'b0;
		end else begin
			// event outputs are single-cycle pulses
			o_step_start     <= 1'b0;
			o_phyretrain_en  <= 1'b0;
			o_train_start    <= 1'b0;
			o_speed_degrade  <= 1'b0;
			o_repair_enter   <= 1'b0;
			o_linkspeed_exit <= 1'b0;
			o_repair_exit    <= 1'b0;
			o_finish         <= 1'b0;
			// ack follows the phase one cycle late, both when rising and falling
			o_mbtrain_ack    <= (phase_q == PH_FINISHED);

			case (phase_q)
				PH_IDLE: begin
					if (i_en) begin
						phase_q         <= PH_RUNNING;
						code_q          <= entry_step(i_entry);
						o_step_start    <= 1'b1;
						o_train_start   <= (i_entry == mbtrain_pkg::ENTRY_FULL);
						o_speed_degrade <= (i_entry == mbtrain_pkg::ENTRY_SPEED_DEGRADE);
						o_repair_enter  <= (i_entry == mbtrain_pkg::ENTRY_REPAIR);
					end
				end
				PH_RUNNING: begin
					if (i_step_done) begin
						case (code_q)
							mbtrain_pkg::STEP_LINK_SPEED: begin
								o_linkspeed_exit <= 1'b1;
								if (i_phy_retrain_req) begin
									phase_q         <= PH_FINISHED;
									o_finish        <= 1'b1;
									o_phyretrain_en <= 1'b1;
								end else if (i_error_req && i_speed_degrade_req) begin
									// retry at a lower speed
									code_q          <= mbtrain_pkg::STEP_SPEED_IDLE;
									o_step_start    <= 1'b1;
									o_speed_degrade <= 1'b1;
								end else if (i_error_req) begin
									code_q         <= mbtrain_pkg::STEP_REPAIR;
									o_step_start   <= 1'b1;
									o_repair_enter <= 1'b1;
								end else begin
									phase_q  <= PH_FINISHED;
									o_finish <= 1'b1;
								end
							end
							mbtrain_pkg::STEP_REPAIR: begin
								// repaired lanes get recalibrated from tx self-cal
								code_q        <= mbtrain_pkg::STEP_TX_SELF_CAL;
								o_step_start  <= 1'b1;
								o_repair_exit <= 1'b1;
							end
							default: begin
								code_q       <= mbtrain_pkg::step_code_t'(code_q + 4'd1);
								o_step_start <= 1'b1;
							end
						endcase
					end
				end
				PH_FINISHED: begin
					if (!i_en) begin
						phase_q <= PH_IDLE;
					end
				end
				default: phase_q <= PH_IDLE;
			endcase
		end
	end

	assign o_step_code = code_q;

endmodule

/* src/mbtrain_link_status.sv */
`timescale 1ns/1ps

module mbtrain_link_status #(
	parameter int SPEED_W         = 3,
	parameter int NUM_LANE_GROUPS = 2
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_train_start,
	input  logic                       i_speed_degrade,
	input  logic                       i_repair_enter,
	input  logic                       i_linkspeed_exit,
	input  logic                       i_repair_exit,
	input  logic                       i_finish,
	input  logic [SPEED_W-1:0]         i_highest_common_speed,
	input  logic [NUM_LANE_GROUPS-1:0] i_tx_lanes_mbinit,
	input  logic [NUM_LANE_GROUPS-1:0] i_rx_lanes_mbinit,
	input  logic [NUM_LANE_GROUPS-1:0] i_tx_lanes_linkspeed,
	input  logic [NUM_LANE_GROUPS-1:0] i_rx_lanes_repair,
	output logic [SPEED_W-1:0]         o_current_speed,
	output logic [NUM_LANE_GROUPS-1:0] o_tx_lanes,
	output logic [NUM_LANE_GROUPS-1:0] o_rx_lanes,
	output logic                       o_coming_from_repair
);

	logic [SPEED_W-1:0]         speed_q;
	logic [NUM_LANE_GROUPS-1:0] tx_lanes_q;
	logic [NUM_LANE_GROUPS-1:0] rx_lanes_q;
	logic                       repair_in_mbinit;
	logic                       repair_in_mbtrain;
	logic                       degrade_from_idle;

	// a degrade without a link speed exit in the same cycle comes from idle
	assign degrade_from_idle = i_speed_degrade && !i_linkspeed_exit;

	// operating speed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			speed_q <= '0;
		end else if (i_train_start) begin
			speed_q <= i_highest_common_speed;
		end else if (i_speed_degrade) begin
			speed_q <= speed_q - 1'b1;
		end
	end

	// functional lane groups
	// tx is settled by link speed, rx by repair
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_lanes_q <= '0;
			rx_lanes_q <= '0;
		end else begin
			if (i_train_start) begin
				tx_lanes_q <= i_tx_lanes_mbinit;
				rx_lanes_q <= i_rx_lanes_mbinit;
			end else begin
				if (i_linkspeed_exit) begin
					tx_lanes_q <= i_tx_lanes_linkspeed;
				end
				if (i_repair_exit) begin
					rx_lanes_q <= i_rx_lanes_repair;
				end
			end
		end
	end

	// mbinit already dropped a tx group, so link speed must not ask for repair again
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			repair_in_mbinit <= 1'b0;
		end else if (i_train_start) begin
			repair_in_mbinit <= ~&i_tx_lanes_mbinit;
		end else if (i_finish) begin
			repair_in_mbinit <= 1'b0;
		end
	end

	// repair run during this training pass
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			repair_in_mbtrain <= 1'b0;
		end else if (i_repair_enter) begin
			repair_in_mbtrain <= 1'b1;
		end else if (i_train_start || degrade_from_idle) begin
			repair_in_mbtrain <= 1'b0;
		end
	end

	assign o_current_speed      = speed_q;
	assign o_tx_lanes           = tx_lanes_q;
	assign o_rx_lanes           = rx_lanes_q;
	assign o_coming_from_repair = repair_in_mbinit | repair_in_mbtrain;

endmodule

/* src/mbtrain_controller.sv */
`timescale 1ns/1ps

module mbtrain_controller #(
	parameter int SPEED_W         = 3,
	parameter int NUM_LANE_GROUPS = 2
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              i_en,
	input  mbtrain_pkg::entry_t               i_phyretrain_resolved_state,
	input  logic [SPEED_W-1:0]                i_highest_common_speed,
	input  logic [mbtrain_pkg::NUM_STEPS-1:0] i_step_ack,
	input  logic                              i_phy_retrain_req,
	input  logic                              i_error_req,
	input  logic                              i_speed_degrade_req,
	input  logic [NUM_LANE_GROUPS-1:0]        i_tx_lanes_mbinit,
	input  logic [NUM_LANE_GROUPS-1:0]        i_rx_lanes_mbinit,
	input  logic [NUM_LANE_GROUPS-1:0]        i_tx_lanes_linkspeed,
	input  logic [NUM_LANE_GROUPS-1:0]        i_rx_lanes_repair,
	output logic [mbtrain_pkg::NUM_STEPS-1:0] o_step_en,
	output mbtrain_pkg::step_code_t           o_sideband_substate,
	output mbtrain_pkg::mux_sel_t             o_mux_sel,
	output logic                              o_phyretrain_en,
	output logic                              o_mbtrain_ack,
	output logic [SPEED_W-1:0]                o_current_speed,
	output logic [NUM_LANE_GROUPS-1:0]        o_tx_lanes,
	output logic [NUM_LANE_GROUPS-1:0]        o_rx_lanes,
	output logic                              o_coming_from_repair
);

	logic                    step_start;
	logic                    step_done;
	mbtrain_pkg::step_code_t step_code;
	logic                    train_start;
	logic                    speed_degrade;
	logic                    repair_enter;
	logic                    linkspeed_exit;
	logic                    repair_exit;
	logic                    finish;

	// substep ordering and link speed outcome
	mbtrain_sequencer u_sequencer (
		.clk                 (clk),
		.rst_n               (rst_n),
		.i_en                (i_en),
		.i_entry             (i_phyretrain_resolved_state),
		.i_step_done         (step_done),
		.i_phy_retrain_req   (i_phy_retrain_req),
		.i_error_req         (i_error_req),
		.i_speed_degrade_req (i_speed_degrade_req),
		.o_step_start        (step_start),
		.o_step_code         (step_code),
		.o_phyretrain_en     (o_phyretrain_en),
		.o_mbtrain_ack       (o_mbtrain_ack),
		.o_train_start       (train_start),
		.o_speed_degrade     (speed_degrade),
		.o_repair_enter      (repair_enter),
		.o_linkspeed_exit    (linkspeed_exit),
		.o_repair_exit       (repair_exit),
		.o_finish            (finish)
	);

	// enable / ack exchange with the substep blocks
	mbtrain_step_handshake u_step_handshake (
		.clk                 (clk),
		.rst_n               (rst_n),
		.i_step_start        (step_start),
		.i_step_code         (step_code),
		.i_step_ack          (i_step_ack),
		.o_step_en           (o_step_en),
		.o_sideband_substate (o_sideband_substate),
		.o_mux_sel           (o_mux_sel),
		.o_step_done         (step_done)
	);

	mbtrain_link_status #(
		.SPEED_W         (SPEED_W),
		.NUM_LANE_GROUPS (NUM_LANE_GROUPS)
	) u_link_status (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.i_train_start          (train_start),
		.i_speed_degrade        (speed_degrade),
		.i_repair_enter         (repair_enter),
		.i_linkspeed_exit       (linkspeed_exit),
		.i_repair_exit          (repair_exit),
		.i_finish               (finish),
		.i_highest_common_speed (i_highest_common_speed),
		.i_tx_lanes_mbinit      (i_tx_lanes_mbinit),
		.i_rx_lanes_mbinit      (i_rx_lanes_mbinit),
		.i_tx_lanes_linkspeed   (i_tx_lanes_linkspeed),
		.i_rx_lanes_repair      (i_rx_lanes_repair),
		.o_current_speed        (o_current_speed),
		.o_tx_lanes             (o_tx_lanes),
		.o_rx_lanes             (o_rx_lanes),
		.o_coming_from_repair   (o_coming_from_repair)
	);

endmodule

/* tb/mbtrain_partner.sv */
`timescale 1ns/1ps

module mbtrain_partner #(
	parameter int NUM_LANE_GROUPS = 2
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [mbtrain_pkg::NUM_STEPS-1:0] i_step_en,
	input  logic                              i_ls_phy_retrain,
	input  logic                              i_ls_error,
	input  logic                              i_ls_degrade,
	input  logic [NUM_LANE_GROUPS-1:0]        i_ls_tx_lanes,
	input  logic [NUM_LANE_GROUPS-1:0]        i_repair_rx_lanes,
	output logic [mbtrain_pkg::NUM_STEPS-1:0] o_step_ack,
	output logic                              o_phy_retrain_req,
	output logic                              o_error_req,
	output logic                              o_speed_degrade_req,
	output logic [NUM_LANE_GROUPS-1:0]        o_tx_lanes_linkspeed,
	output logic [NUM_LANE_GROUPS-1:0]        o_rx_lanes_repair
);

	logic held;
	int   idx;
	int   delay;

	function automatic int first_enabled(input logic [mbtrain_pkg::NUM_STEPS-1:0] en);
		int pos;
		pos = 0;
		for (int i = mbtrain_pkg::NUM_STEPS - 1; i >= 0; i--) begin
			if (en[i]) begin
				pos = i;
			end
		end
		return pos;
	endfunction

	// request flags only visible around the link speed ack
	assign o_phy_retrain_req    = held & i_ls_phy_retrain;
	assign o_error_req          = held & i_ls_error;
	assign o_speed_degrade_req  = held & i_ls_degrade;
	assign o_tx_lanes_linkspeed = i_ls_tx_lanes;
	assign o_rx_lanes_repair    = i_repair_rx_lanes;

	initial begin
		void'($urandom(32'h73f7_3692));
		o_step_ack = '0;
		held = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			if (rst_n && (i_step_en != '0)) begin
				idx = first_enabled(i_step_en);
				delay = $urandom_range(8, 1);
				repeat (delay) @(posedge clk);
				#2;
				o_step_ack[idx] = 1'b1;
				held = (idx == int'(mbtrain_pkg::STEP_LINK_SPEED));
				while (i_step_en[idx]) begin
					@(posedge clk);
					#2;
				end
				delay = $urandom_range(4, 1);
				repeat (delay) @(posedge clk);
				#2;
				o_step_ack[idx] = 1'b0;
				// keep flags one more cycle past the ack falling
				@(posedge clk);
				#2;
				held = 1'b0;
			end
		end
	end

endmodule

/* tb/tb_mbtrain.sv */
`timescale 1ns/1ps

module tb_mbtrain;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 8;
	localparam int WAIT_LIMIT = 600;

	logic                              clk;
	logic                              rst_n;
	logic                              i_en;
	mbtrain_pkg::entry_t               i_phyretrain_resolved_state;
	logic [2:0]                        i_highest_common_speed;
	logic [mbtrain_pkg::NUM_STEPS-1:0] i_step_ack;
	logic                              i_phy_retrain_req;
	logic                              i_error_req;
	logic                              i_speed_degrade_req;
	logic [1:0]                        i_tx_lanes_mbinit;
	logic [1:0]                        i_rx_lanes_mbinit;
	logic [1:0]                        i_tx_lanes_linkspeed;
	logic [1:0]                        i_rx_lanes_repair;
	logic [mbtrain_pkg::NUM_STEPS-1:0] o_step_en;
	mbtrain_pkg::step_code_t           o_sideband_substate;
	mbtrain_pkg::mux_sel_t             o_mux_sel;
	logic                              o_phyretrain_en;
	logic                              o_mbtrain_ack;
	logic [2:0]                        o_current_speed;
	logic [1:0]                        o_tx_lanes;
	logic [1:0]                        o_rx_lanes;
	logic                              o_coming_from_repair;

	// values the partner presents at link speed and repair
	logic                              ls_retrain;
	logic                              ls_error;
	logic                              ls_degrade;
	logic [1:0]                        ls_tx;
	logic [1:0]                        rep_rx;

	int                                errors;
	int                                errors_at_start;
	int                                tests_run;
	int                                tests_failed;
	int                                retrain_pulses;
	logic                              ack_at_pulse;
	logic [mbtrain_pkg::NUM_STEPS-1:0] prev_en;
	int                                seen[$];
	int                                expected[$];

	mbtrain_controller DUT (.*);

	mbtrain_partner partner (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_step_en            (o_step_en),
		.i_ls_phy_retrain     (ls_retrain),
		.i_ls_error           (ls_error),
		.i_ls_degrade         (ls_degrade),
		.i_ls_tx_lanes        (ls_tx),
		.i_repair_rx_lanes    (rep_rx),
		.o_step_ack           (i_step_ack),
		.o_phy_retrain_req    (i_phy_retrain_req),
		.o_error_req          (i_error_req),
		.o_speed_degrade_req  (i_speed_degrade_req),
		.o_tx_lanes_linkspeed (i_tx_lanes_linkspeed),
		.o_rx_lanes_repair    (i_rx_lanes_repair)
	);

	// pattern class per substep code
	function automatic logic [2:0] expected_class(input logic [3:0] code);
		case (code)
			4'd0, 4'd1, 4'd6, 4'd8: return 3'd0;
			4'd2, 4'd3:             return 3'd1;
			4'd11:                  return 3'd2;
			4'd12:                  return 3'd3;
			4'd5, 4'd7, 4'd10:      return 3'd4;
			4'd4, 4'd9:             return 3'd5;
			default:                return 3'd7;
		endcase
	endfunction

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(o_step_en))
		else begin
			errors++;
			$display("more than one substep enable was high at %0t", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(|o_step_en) |-> (o_step_en == (13'd1 << o_sideband_substate)))
		else begin
			errors++;
			$display("mismatch o_sideband_substate: got 0x%0h, enables 0x%0h",
				o_sideband_substate, o_step_en);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(|o_step_en) |-> (o_mux_sel == expected_class(o_sideband_substate)))
		else begin
			errors++;
			$display("mismatch o_mux_sel: got 0x%0h, expected 0x%0h", o_mux_sel,
				expected_class(o_sideband_substate));
		end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// scoreboard with one entry per enable rise
	task automatic record_rises();
		for (int i = 0; i < mbtrain_pkg::NUM_STEPS; i++) begin
			if (o_step_en[i] && !prev_en[i]) begin
				seen.push_back(i);
			end
		end
		prev_en = o_step_en;
	endtask

	always @(negedge clk) begin
		record_rises();
		if (o_phyretrain_en) begin
			retrain_pulses++;
			ack_at_pulse = ack_at_pulse | o_mbtrain_ack;
		end
	end

	task automatic add_steps(input int first, input int last);
		for (int i = first; i <= last; i++) begin
			expected.push_back(i);
		end
	endtask

	task automatic start_run(input mbtrain_pkg::entry_t entry_sel);
		seen.delete();
		expected.delete();
		retrain_pulses = 0;
		ack_at_pulse = 1'b0;
		errors_at_start = errors;
		@(posedge clk);
		#2;
		i_phyretrain_resolved_state = entry_sel;
		i_en = 1'b1;
	endtask

	task automatic wait_step(input int code);
		int n;
		n = 0;
		while (!o_step_en[code] && n < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!o_step_en[code]) begin
			errors++;
			$display("timed out waiting for the enable of substep %0d", code);
		end
	endtask

	task automatic wait_done(input int exp_pulses);
		int n;
		n = 0;
		while (!o_mbtrain_ack && n < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!o_mbtrain_ack) begin
			errors++;
			$display("timed out waiting for o_mbtrain_ack");
		end
		check_val("step count", seen.size(), expected.size());
		for (int i = 0; i < expected.size() && i < seen.size(); i++) begin
			check_val("step order", seen[i], expected[i]);
		end
		check_val("o_phyretrain_en cycles", retrain_pulses, exp_pulses);
		assert (!ack_at_pulse) else begin
			errors++;
			$display("o_phyretrain_en came after o_mbtrain_ack had risen");
		end
	endtask

	// ack must follow within two cycles of i_en dropping
	task automatic release_run();
		i_en = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#2;
		end
		check_val("o_mbtrain_ack", o_mbtrain_ack, 0);
		repeat (2) begin
			@(posedge clk);
			#2;
		end
		check_val("o_step_en", o_step_en, 0);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errors_at_start);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * 20 * 20 * CLK_PERIOD);
		$display("watchdog expired before all tests completed");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		retrain_pulses = 0;
		ack_at_pulse = 1'b0;
		prev_en = '0;
		rst_n = 1'b0;
		i_en = 1'b0;
		i_phyretrain_resolved_state = mbtrain_pkg::ENTRY_FULL;
		i_highest_common_speed = 3'd5;
		i_tx_lanes_mbinit = 2'b11;
		i_rx_lanes_mbinit = 2'b10;
		ls_retrain = 1'b0;
		ls_error = 1'b0;
		ls_degrade = 1'b0;
		ls_tx = 2'b01;
		rep_rx = 2'b11;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_val("outputs after reset", {o_step_en, o_sideband_substate, o_mux_sel,
			o_phyretrain_en, o_mbtrain_ack, o_current_speed, o_tx_lanes, o_rx_lanes,
			o_coming_from_repair}, 0);

		start_run(mbtrain_pkg::ENTRY_FULL);
		add_steps(0, 11);
		wait_done(0);
		check_val("o_current_speed", o_current_speed, 5);
		check_val("o_rx_lanes", o_rx_lanes, 2'b10);
		check_val("o_tx_lanes", o_tx_lanes, 2'b01);
		check_val("o_coming_from_repair", o_coming_from_repair, 0);
		release_run();
		end_test("full training");

		ls_tx = 2'b10;
		start_run(mbtrain_pkg::ENTRY_TX_SELF_CAL);
		add_steps(3, 11);
		wait_done(0);
		check_val("o_tx_lanes", o_tx_lanes, 2'b10);
		check_val("o_current_speed", o_current_speed, 5);
		release_run();
		end_test("entry tx self-cal");

		start_run(mbtrain_pkg::ENTRY_SPEED_DEGRADE);
		add_steps(2, 11);
		wait_done(0);
		check_val("o_current_speed", o_current_speed, 4);
		release_run();
		end_test("entry speed degrade");

		rep_rx = 2'b01;
		start_run(mbtrain_pkg::ENTRY_REPAIR);
		add_steps(12, 12);
		add_steps(3, 11);
		wait_done(0);
		check_val("o_coming_from_repair", o_coming_from_repair, 1);
		check_val("o_rx_lanes", o_rx_lanes, 2'b01);
		release_run();
		end_test("entry repair");

		// error with degrade at the first link speed only
		i_highest_common_speed = 3'd6;
		ls_error = 1'b1;
		ls_degrade = 1'b1;
		start_run(mbtrain_pkg::ENTRY_FULL);
		add_steps(0, 11);
		add_steps(2, 11);
		wait_step(11);
		wait_step(2);
		ls_error = 1'b0;
		ls_degrade = 1'b0;
		wait_done(0);
		check_val("o_current_speed", o_current_speed, 5);
		check_val("o_coming_from_repair", o_coming_from_repair, 0);
		release_run();
		end_test("link speed error and degrade");

		rep_rx = 2'b00;
		ls_error = 1'b1;
		start_run(mbtrain_pkg::ENTRY_FULL);
		add_steps(0, 11);
		add_steps(12, 12);
		add_steps(3, 11);
		wait_step(12);
		ls_error = 1'b0;
		wait_done(0);
		check_val("o_coming_from_repair", o_coming_from_repair, 1);
		check_val("o_rx_lanes", o_rx_lanes, 2'b00);
		release_run();
		end_test("link speed error to repair");

		ls_retrain = 1'b1;
		start_run(mbtrain_pkg::ENTRY_FULL);
		add_steps(0, 11);
		wait_done(1);
		release_run();
		ls_retrain = 1'b0;
		end_test("link speed retrain request");

		// one tx group lost in mbinit
		i_tx_lanes_mbinit = 2'b01;
		start_run(mbtrain_pkg::ENTRY_FULL);
		add_steps(0, 11);
		wait_step(11);
		check_val("o_coming_from_repair", o_coming_from_repair, 1);
		wait_done(0);
		check_val("o_coming_from_repair", o_coming_from_repair, 0);
		release_run();
		end_test("mbinit repair history");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src.f */
src/mbtrain_pkg.sv
src/mbtrain_step_handshake.sv
src/mbtrain_sequencer.sv
src/mbtrain_link_status.sv
src/mbtrain_controller.sv
tb/mbtrain_partner.sv
tb/tb_mbtrain.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mbtrain
RTL_TOP    := mbtrain_controller
FILELIST   := src.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
